// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f sim.f \
		--top-module fft27_tb -Mdir obj_dir
	./obj_dir/Vfft27_tb | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: butterfly/radix3_butterfly.sv
`default_nettype none

// 3-point DFT, W = exp(-j*2*pi/3)
// y1 = x0 - (x1+x2)/2 - j*sin60*(x1-x2)
// y2 = x0 - (x1+x2)/2 + j*sin60*(x1-x2)
module radix3_butterfly import fft27_pkg::*; (
    input  cplx_t x0,                           // Oldest sample
    input  cplx_t x1,
    input  cplx_t x2,                           // Newest sample
    output cplx_t y0,                           // Bin 0
    output cplx_t y1,                           // Bin 1
    output cplx_t y2                            // Bin 2
);

    localparam int ACC_W = DATA_W + TW_W + 3;  // Headroom for Q15 sums
    localparam logic signed [ACC_W-1:0] RND =
        {{(ACC_W-TW_W+1){1'b0}}, 1'b1, {(TW_W-2){1'b0}}};  // Half LSB at bit 14

    logic signed [DATA_W:0]  s_re, s_im;       // x1 + x2
    logic signed [DATA_W:0]  d_re, d_im;       // x1 - x2
    logic signed [ACC_W-1:0] t_re, t_im;       // x0 - s/2, Q15
    logic signed [ACC_W-1:0] r_re, r_im;       // sin60 * d, Q15

    // Round half up and drop the Q15 fraction
    function automatic logic signed [DATA_W-1:0] q15_round(
        input logic signed [ACC_W-1:0] acc
    );
        logic signed [ACC_W-1:0] r;
        r = acc + RND;
        return r[TW_W-1 +: DATA_W];
    endfunction

    always_comb begin
        s_re = x1.re + x2.re;
        s_im = x1.im + x2.im;
        d_re = x1.re - x2.re;
        d_im = x1.im - x2.im;
        // Common term, exact since C_HALF is a pure shift
        t_re = (ACC_W'(x0.re) <<< (TW_W - 1)) - s_re * C_HALF;
        t_im = (ACC_W'(x0.im) <<< (TW_W - 1)) - s_im * C_HALF;
        // Rotation by -j folded into the swap
        r_re = d_im * C_SIN60;
        r_im = d_re * C_SIN60;

        y0.re = DATA_W'(s_re + x0.re);          // Plain sum, wraps on overflow
        y0.im = DATA_W'(s_im + x0.im);
        y1.re = q15_round(t_re + r_re);
        y1.im = q15_round(t_im - r_im);
        y2.re = q15_round(t_re - r_re);
        y2.im = q15_round(t_im + r_im);
    end

endmodule

`default_nettype wire

// File: common/fft27_pkg.sv
`default_nettype none

package fft27_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int DATA_W    = 16;              // Bits per real or imag component
    localparam int TW_W      = 16;              // Twiddle component, Q1.15
    localparam int CNT_W     = 5;               // Phase and exponent counters

    // --------------------------------------------------
    // Frame
    // --------------------------------------------------
    localparam int FRAME_LEN = 27;              // Samples per transform

    // --------------------------------------------------
    // Fixed-point constants, Q15
    // --------------------------------------------------
    localparam logic signed [TW_W-1:0] C_HALF  = 16'sd16384;  // 0.5
    localparam logic signed [TW_W-1:0] C_SIN60 = 16'sd28378;  // sin(60 deg)

    // --------------------------------------------------
    // Sample types
    // --------------------------------------------------
    // One complex sample
    typedef struct packed {
        logic signed [DATA_W-1:0] re;           // Real part
        logic signed [DATA_W-1:0] im;           // Imag part
    } cplx_t;

    // Sample with its valid strobe
    typedef struct packed {
        logic  en;                              // Sample valid this cycle
        cplx_t d;                               // Payload
    } smp_t;

endpackage

`default_nettype wire

// File: rtl/delay_line.sv
`default_nettype none

module delay_line import fft27_pkg::*; #(
    parameter int DEPTH = 9                     // Delay in cycles
) (
    input  logic  clk,
    input  cplx_t din,                          // Sample in
    output cplx_t dout                          // Sample from DEPTH cycles ago
);

    cplx_t taps [DEPTH];                        // Register chain

    // Plain shift every cycle
    always_ff @(posedge clk) begin
        taps[0] <= din;                         // Head of chain
        for (int i = 1; i < DEPTH; i++) begin
            taps[i] <= taps[i-1];               // Move one slot along
        end
    end

    assign dout = taps[DEPTH-1];                // Tail of chain

endmodule

`default_nettype wire

// File: rtl/fft27_top.sv
`default_nettype none

// 27-point FFT, output in base-3 digit-reversed order
module fft27_top import fft27_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  smp_t in,                            // Natural order input
    output smp_t out                            // 31 cycles after in
);

    smp_t s1_out;                               // After span 9 butterflies
    smp_t t1_out;                               // After first twiddle
    smp_t s2_out;                               // After span 3 butterflies
    smp_t t2_out;                               // After second twiddle

    // --------------------------------------------------
    // Pipeline 19 + 1 + 7 + 1 + 3
    // --------------------------------------------------
    sdf_stage #(.SPAN(9)) u_stage1 (
        .clk (clk), .rst (rst),
        .din (in),
        .dout (s1_out)
    );

    twiddle_mult #(.SPAN(9)) u_tw1 (
        .clk (clk), .rst (rst),
        .din (s1_out),
        .dout (t1_out)
    );

    sdf_stage #(.SPAN(3)) u_stage2 (
        .clk (clk), .rst (rst),
        .din (t1_out),
        .dout (s2_out)
    );

    twiddle_mult #(.SPAN(3)) u_tw2 (
        .clk (clk), .rst (rst),
        .din (s2_out),
        .dout (t2_out)
    );

    sdf_stage #(.SPAN(1)) u_stage3 (
        .clk (clk), .rst (rst),
        .din (t2_out),
        .dout (out)
    );

endmodule

`default_nettype wire

// File: rtl/sdf_stage.sv
`default_nettype none

// Radix-3 SDF stage
// Group 0 of a block fills the long line, group 1 the short line.
// Group 2 fires the butterfly. y0 leaves at once, y1 and y2 go back
// into the lines and drain during the following two groups.
module sdf_stage import fft27_pkg::*; #(
    parameter int SPAN = 9                      // Distance between butterfly inputs
) (
    input  logic clk,
    input  logic rst,
    input  smp_t din,
    output smp_t dout                           // 2*SPAN+1 cycles behind din
);

    localparam int LAT = 2 * SPAN + 1;          // Stage latency
    localparam logic [CNT_W-1:0] PH_LAST = CNT_W'(3 * SPAN - 1);
    localparam logic [CNT_W-1:0] SPAN_W  = CNT_W'(SPAN);
    localparam logic [CNT_W-1:0] SPAN2_W = CNT_W'(2 * SPAN);

    logic [CNT_W-1:0] phase;                    // Slot in 3*SPAN block
    logic [1:0]       grp;                      // Group of phase
    logic [LAT-1:0]   vld_pipe;                 // din.en history
    logic             busy;                     // Input or drain in progress
    cplx_t            long_in, long_out;        // 2*SPAN line
    cplx_t            short_in, short_out;      // SPAN line
    cplx_t            y0, y1, y2;               // Butterfly results
    cplx_t            sp_d;                     // Single-path output, pre-reg
    cplx_t            out_d;                    // Output register

    // --------------------------------------------------
    // Phase control
    // --------------------------------------------------
    // Keeps counting until the last output has left the mux
    assign busy = din.en | (|vld_pipe[LAT-2:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
        end else if (busy) begin
            phase <= (phase == PH_LAST) ? '0 : phase + 1'b1;
        end else begin
            phase <= '0;                        // Idle, realign for next frame
        end
    end

    always_comb begin
        if (phase < SPAN_W) begin
            grp = 2'd0;
        end else if (phase < SPAN2_W) begin
            grp = 2'd1;
        end else begin
            grp = 2'd2;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LAT-2:0], din.en};  // Several frames may be in flight
        end
    end

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    radix3_butterfly u_bf (
        .x0 (long_out),                         // Group 0 sample
        .x1 (short_out),                        // Group 1 sample
        .x2 (din.d),                            // Group 2 sample
        .y0 (y0),
        .y1 (y1),
        .y2 (y2)
    );

    // Line inputs outside the fill slots are never read back
    assign long_in  = (grp == 2'd2) ? y2 : din.d;
    assign short_in = (grp == 2'd2) ? y1 : din.d;

    delay_line #(.DEPTH(2 * SPAN)) u_dl_long (
        .clk  (clk),
        .din  (long_in),
        .dout (long_out)
    );

    delay_line #(.DEPTH(SPAN)) u_dl_short (
        .clk  (clk),
        .din  (short_in),
        .dout (short_out)
    );

    always_comb begin
        case (grp)
            2'd2:    sp_d = y0;                 // Bin 0 straight out
            2'd0:    sp_d = short_out;          // Bin 1 back from short line
            default: sp_d = long_out;           // Bin 2 back from long line
        endcase
    end

    always_ff @(posedge clk) begin
        out_d <= sp_d;
    end

    assign dout = '{en: vld_pipe[LAT-1], d: out_d};

endmodule

`default_nettype wire

// File: sim.f
common/fft27_pkg.sv
rtl/delay_line.sv
butterfly/radix3_butterfly.sv
twiddle/twiddle_rom.sv
twiddle/twiddle_mult.sv
rtl/sdf_stage.sv
rtl/fft27_top.sv
tests/fft27_tb.sv

// File: tests/fft27_tb.sv
`default_nettype none

module fft27_tb import fft27_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int        FRAME_LATENCY = 31;           // 19 + 1 + 7 + 1 + 3
    localparam int        RST_CYCLES    = 5;
    localparam int        WAIT_LIMIT    = 100;          // Cycles without output before giving up
    localparam int        SETTLE        = 10;           // Quiet cycles after a run
    localparam int        MAX_FRAMES    = 3;
    localparam int        GAP_CYCLES    = 40;           // Idle cycles between two frames
    localparam int        TOL_FINE      = 4;            // Impulse path is nearly exact
    localparam int        TOL_COARSE    = 16;           // Twiddle rounding through three stages
    localparam bit [31:0] SEED          = 32'h96c50bf3;
    localparam real       PI            = 3.14159265358979;

    logic  clk = 1'b0;
    logic  rst;
    smp_t  fft_in;
    smp_t  fft_out;

    int    cyc = 0;                                     // Rising edges since start
    int    first_in_cyc;                                // Cycle of first in.en of a run
    cplx_t got_q [$];                                   // Captured output samples
    int    got_cyc [$];                                 // Cycle of each capture
    int    src_re [MAX_FRAMES][FRAME_LEN];              // Stimulus real part
    int    src_im [MAX_FRAMES][FRAME_LEN];              // Stimulus imag part

    fft27_top uut (
        .clk (clk),
        .rst (rst),
        .in  (fft_in),
        .out (fft_out)
    );

    always #5 clk = ~clk;                               // 10 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Sample at the falling edge away from register updates
    always @(negedge clk) begin
        if (fft_out.en === 1'b1) begin
            got_q.push_back(fft_out.d);
            got_cyc.push_back(cyc);
        end
    end

    // --------------------------------------------------
    // Reporting and reference model
    // --------------------------------------------------
    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    function automatic string err_line(input string msg);
        return $sformatf("ERROR @%0t: %s", $time, msg);
    endfunction

    function automatic real abs_real(input real v);
        return (v < 0.0) ? -v : v;
    endfunction

    // Slot (a,b,c) most significant first holds bin c*9+b*3+a
    function automatic int digit_rev(input int j);
        int a;
        int b;
        int c;
        a = j / 9;
        b = (j / 3) % 3;
        c = j % 3;
        return c * 9 + b * 3 + a;
    endfunction

    // Direct DFT X[k] = sum x[n] * exp(-j*2*pi*n*k/27)
    function automatic real ref_dft(input int f, input int k, input bit want_im);
        real acc_re;
        real acc_im;
        real ang;
        real xr;
        real xi;
        acc_re = 0.0;
        acc_im = 0.0;
        for (int n = 0; n < FRAME_LEN; n++) begin
            ang    = 2.0 * PI * real'((n * k) % FRAME_LEN) / real'(FRAME_LEN);
            xr     = real'(src_re[f][n]);
            xi     = real'(src_im[f][n]);
            acc_re += xr * $cos(ang) + xi * $sin(ang);
            acc_im += xi * $cos(ang) - xr * $sin(ang);
        end
        return want_im ? acc_im : acc_re;
    endfunction

    // --------------------------------------------------
    // Stimulus and capture
    // --------------------------------------------------
    task automatic load_const(input int f, input int re_val, input int im_val);
        for (int n = 0; n < FRAME_LEN; n++) begin
            src_re[f][n] = re_val;
            src_im[f][n] = im_val;
        end
    endtask

    task automatic load_impulse(input int f, input int amp);
        load_const(f, 0, 0);
        src_re[f][0] = amp;                             // Sample 0 only
    endtask

    task automatic load_random(input int f, input int amp);
        for (int n = 0; n < FRAME_LEN; n++) begin
            src_re[f][n] = int'($urandom_range(2 * amp, 0)) - amp;
            src_im[f][n] = int'($urandom_range(2 * amp, 0)) - amp;
        end
    endtask

    task automatic clear_capture();
        got_q.delete();
        got_cyc.delete();
    endtask

    // Frames first..first+n_frames-1 back-to-back and then one idle slot
    task automatic send_frames(input int first, input int n_frames);
        for (int f = first; f < first + n_frames; f++) begin
            for (int i = 0; i < FRAME_LEN; i++) begin
                @(posedge clk);
                #1;
                if (f == first && i == 0) begin
                    first_in_cyc = cyc;                 // Latency reference
                end
                fft_in.en   = 1'b1;
                fft_in.d.re = DATA_W'(src_re[f][i]);
                fft_in.d.im = DATA_W'(src_im[f][i]);
            end
        end
        @(posedge clk);
        #1;
        fft_in = '0;
    endtask

    // Timer restarts whenever a new output shows up
    task automatic wait_outputs(input int n);
        int idle_cnt;
        int last_size;
        idle_cnt  = 0;
        last_size = got_q.size();
        while (got_q.size() < n) begin
            @(posedge clk);
            if (got_q.size() != last_size) begin
                last_size = got_q.size();
                idle_cnt  = 0;
            end else begin
                idle_cnt++;
            end
            if (idle_cnt >= WAIT_LIMIT) begin
                fail_now($sformatf("Timeout: no DUT output for %0d cycles, got %0d of %0d",
                    WAIT_LIMIT, got_q.size(), n));
            end
        end
    endtask

    // Latency of output base and no gaps in the n outputs from there
    task automatic check_timing(input int base, input int n);
        assert (got_cyc[base] - first_in_cyc == FRAME_LATENCY) else
            fail_now(err_line($sformatf("latency %0d cycles, expected %0d",
                got_cyc[base] - first_in_cyc, FRAME_LATENCY)));
        for (int i = 1; i < n; i++) begin
            assert (got_cyc[base + i] == got_cyc[base] + i) else
                fail_now(err_line($sformatf("out.en gap before output %0d", base + i)));
        end
    endtask

    // No stray outputs after the expected ones
    task automatic expect_count(input int n);
        repeat (SETTLE) @(posedge clk);
        assert (got_q.size() == n) else
            fail_now(err_line($sformatf("%0d outputs, expected %0d", got_q.size(), n)));
    endtask

    task automatic check_frame(input int f, input int base, input int tol);
        cplx_t got;
        real   exp_re;
        real   exp_im;
        real   err_re;
        real   err_im;
        int    bin;
        for (int j = 0; j < FRAME_LEN; j++) begin
            got    = got_q[base + j];
            bin    = digit_rev(j);
            exp_re = ref_dft(f, bin, 1'b0);
            exp_im = ref_dft(f, bin, 1'b1);
            assert (!$isunknown(got)) else
                fail_now(err_line($sformatf("frame %0d slot %0d has unknown bits", f, j)));
            err_re = real'(got.re) - exp_re;
            err_im = real'(got.im) - exp_im;
            assert (abs_real(err_re) <= tol && abs_real(err_im) <= tol) else
                fail_now(err_line($sformatf(
                    "frame %0d slot %0d bin %0d got (%0d,%0d) expected (%.1f,%.1f)",
                    f, j, bin, got.re, got.im, exp_re, exp_im)));
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic reset_state();
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
            #1;
            assert (fft_out.en === 1'b0) else
                fail_now(err_line("out.en not low during reset"));
        end
        rst = 1'b0;
        for (int i = 0; i < 2 * FRAME_LATENCY; i++) begin
            @(negedge clk);
            assert (fft_out.en === 1'b0) else
                fail_now(err_line("out.en high with no input"));
        end
    endtask

    task automatic zero_frame();
        load_const(0, 0, 0);
        clear_capture();
        send_frames(0, 1);
        wait_outputs(FRAME_LEN);
        check_timing(0, FRAME_LEN);
        expect_count(FRAME_LEN);
        check_frame(0, 0, 0);                           // Exactly zero
    endtask

    task automatic impulse_frame();
        load_impulse(0, 1000);
        clear_capture();
        send_frames(0, 1);
        wait_outputs(FRAME_LEN);
        check_timing(0, FRAME_LEN);
        expect_count(FRAME_LEN);
        check_frame(0, 0, TOL_FINE);                    // Flat spectrum of 1000
    endtask

    task automatic constant_frame();
        load_const(0, 500, 0);
        clear_capture();
        send_frames(0, 1);
        wait_outputs(FRAME_LEN);
        check_timing(0, FRAME_LEN);
        expect_count(FRAME_LEN);
        check_frame(0, 0, TOL_COARSE);                  // 13500 in bin 0
    endtask

    task automatic random_frames();
        for (int f = 0; f < MAX_FRAMES; f++) begin
            load_random(f, 1000);
        end
        clear_capture();
        send_frames(0, MAX_FRAMES);                     // Several frames in flight
        wait_outputs(MAX_FRAMES * FRAME_LEN);
        check_timing(0, MAX_FRAMES * FRAME_LEN);
        expect_count(MAX_FRAMES * FRAME_LEN);
        for (int f = 0; f < MAX_FRAMES; f++) begin
            check_frame(f, f * FRAME_LEN, TOL_COARSE);
        end
    endtask

    task automatic gap_frame();
        load_random(0, 1000);
        load_random(1, 1000);
        clear_capture();
        send_frames(0, 1);
        repeat (GAP_CYCLES - 1) @(posedge clk);         // First idle slot comes from send_frames
        send_frames(1, 1);                              // Latency taken from this frame
        wait_outputs(2 * FRAME_LEN);
        check_timing(FRAME_LEN, FRAME_LEN);
        expect_count(2 * FRAME_LEN);
        check_frame(0, 0, TOL_COARSE);
        check_frame(1, FRAME_LEN, TOL_COARSE);
    endtask

    initial begin
        rst    = 1'b1;
        fft_in = '0;
        void'($urandom(SEED));
        reset_state();
        zero_frame();
        impulse_frame();
        constant_frame();
        random_frames();
        gap_frame();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: twiddle/twiddle_mult.sv
`default_nettype none

module twiddle_mult import fft27_pkg::*; #(
    parameter int SPAN = 9                      // Span of the preceding stage
) (
    input  logic clk,
    input  logic rst,
    input  smp_t din,
    output smp_t dout                           // One cycle behind din
);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(3 * SPAN - 1);
    localparam logic [CNT_W-1:0] SPAN_W   = CNT_W'(SPAN);
    localparam logic [CNT_W-1:0] SPAN2_W  = CNT_W'(2 * SPAN);
    localparam logic [CNT_W-1:0] TW_STEP  = CNT_W'(FRAME_LEN / (3 * SPAN));  // 9/SPAN
    localparam int PROD_W = DATA_W + TW_W;
    localparam logic signed [PROD_W:0] RND =
        {{(DATA_W+2){1'b0}}, 1'b1, {(TW_W-2){1'b0}}};  // Half LSB of Q15

    logic [CNT_W-1:0]         cnt;              // Valid sample index in block
    logic [CNT_W-1:0]         grp;              // Group p, 0..2
    logic [CNT_W-1:0]         ofs;              // Offset q in group
    logic [CNT_W-1:0]         tw_exp;           // p*q*(9/SPAN)
    cplx_t                    tw;               // ROM output
    logic signed [PROD_W-1:0] p_rr, p_ii, p_ri, p_ir;
    logic signed [PROD_W:0]   acc_re, acc_im;
    logic                     en_q;
    cplx_t                    d_q;

    // Count valid samples modulo 3*SPAN
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (din.en) begin
            cnt <= (cnt == CNT_LAST) ? '0 : cnt + 1'b1;
        end
    end

    always_comb begin
        if (cnt < SPAN_W) begin
            grp = '0;
            ofs = cnt;
        end else if (cnt < SPAN2_W) begin
            grp = CNT_W'(1);
            ofs = cnt - SPAN_W;
        end else begin
            grp = CNT_W'(2);
            ofs = cnt - SPAN2_W;
        end
        tw_exp = grp * ofs * TW_STEP;           // Peaks at 16, no wrap needed
    end

    twiddle_rom u_rom (
        .addr (tw_exp),
        .tw   (tw)
    );

    // Complex product, Q15 twiddle
    assign p_rr   = din.d.re * tw.re;
    assign p_ii   = din.d.im * tw.im;
    assign p_ri   = din.d.re * tw.im;
    assign p_ir   = din.d.im * tw.re;
    assign acc_re = p_rr - p_ii + RND;
    assign acc_im = p_ri + p_ir + RND;

    always_ff @(posedge clk) begin
        if (tw_exp == '0) begin
            d_q <= din.d;                       // Exponent 0 passes exactly
        end else begin
            d_q.re <= acc_re[TW_W-1 +: DATA_W];
            d_q.im <= acc_im[TW_W-1 +: DATA_W];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_q <= 1'b0;
        end else begin
            en_q <= din.en;
        end
    end

    assign dout = '{en: en_q, d: d_q};

endmodule

`default_nettype wire

// File: twiddle/twiddle_rom.sv
`default_nettype none

// Entry e = cos(2*pi*e/27) - j*sin(2*pi*e/27)
module twiddle_rom import fft27_pkg::*; (
    input  logic [CNT_W-1:0] addr,              // Exponent
    output cplx_t            tw                 // Q15 twiddle
);

    always_comb begin
        case (addr)
            5'd0:    tw = '{re:  16'sd32767, im:  16'sd0};     // Max positive Q15
            5'd1:    tw = '{re:  16'sd31885, im: -16'sd7557};
            5'd2:    tw = '{re:  16'sd29283, im: -16'sd14706};
            5'd3:    tw = '{re:  16'sd25102, im: -16'sd21063};
            5'd4:    tw = '{re:  16'sd19568, im: -16'sd26284};
            5'd5:    tw = '{re:  16'sd12979, im: -16'sd30088};
            5'd6:    tw = '{re:  16'sd5690,  im: -16'sd32270};
            5'd7:    tw = '{re: -16'sd1905,  im: -16'sd32713};
            5'd8:    tw = '{re: -16'sd9398,  im: -16'sd31391};
            5'd9:    tw = '{re: -16'sd16384, im: -16'sd28378}; // 120 deg
            5'd10:   tw = '{re: -16'sd22487, im: -16'sd23835};
            5'd11:   tw = '{re: -16'sd27377, im: -16'sd18006};
            5'd12:   tw = '{re: -16'sd30792, im: -16'sd11207};
            5'd13:   tw = '{re: -16'sd32546, im: -16'sd3804};
            5'd14:   tw = '{re: -16'sd32546, im:  16'sd3804};
            5'd15:   tw = '{re: -16'sd30792, im:  16'sd11207};
            5'd16:   tw = '{re: -16'sd27377, im:  16'sd18006};
            5'd17:   tw = '{re: -16'sd22487, im:  16'sd23835};
            5'd18:   tw = '{re: -16'sd16384, im:  16'sd28378}; // 240 deg
            5'd19:   tw = '{re: -16'sd9398,  im:  16'sd31391};
            5'd20:   tw = '{re: -16'sd1905,  im:  16'sd32713};
            5'd21:   tw = '{re:  16'sd5690,  im:  16'sd32270};
            5'd22:   tw = '{re:  16'sd12979, im:  16'sd30088};
            5'd23:   tw = '{re:  16'sd19568, im:  16'sd26284};
            5'd24:   tw = '{re:  16'sd25102, im:  16'sd21063};
            5'd25:   tw = '{re:  16'sd29283, im:  16'sd14706};
            5'd26:   tw = '{re:  16'sd31885, im:  16'sd7557};
            default: tw = '0;                   // Addresses past the table
        endcase
    end

endmodule

`default_nettype wire
